// ==== lockstep_pkg.sv ====
/*
  Shared types and constants for the lockstep checker and its small core.
  Bus addresses are byte addresses and every access is one 32-bit word.
  BURST_LEN must be at least 2 so that the burst counter has one bit or more.
*/
package lockstep_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Reads per accumulation burst
  localparam int unsigned BURST_LEN = 4;

  typedef logic [$clog2(BURST_LEN)-1:0] burst_cnt_t;

  // First read address, word aligned
  localparam addr_t BASE_ADDR = 32'h0000_1000;

  // The sum lands right after the burst window
  localparam addr_t WRITE_ADDR = BASE_ADDR + addr_t'(4 * BURST_LEN);

  ////////////////////////////////////////
  // Core boundary
  ////////////////////////////////////////

  // Everything the core samples
  typedef struct packed {
    logic  data_gnt;
    logic  data_rvalid;
    data_t data_rdata;
    logic  data_err;
    logic  fetch_en;
  } core_in_t;

  // Everything the core drives, compared by the checker
  typedef struct packed {
    logic  data_req;
    logic  data_we;
    addr_t data_addr;
    data_t data_wdata;
  } core_out_t;

endpackage

// ==== acc_core.sv ====
/*
  Small accumulator core. It reads BURST_LEN words from BASE_ADDR and sums them,
  then writes the sum to WRITE_ADDR. A request is held until data_gnt is seen.
  Errored reads still add their data. alert_bus_o pulses one cycle after an error.
*/
`timescale 1ns/1ps

module acc_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_i,
  output lockstep_pkg::core_out_t core_o,
  output logic                    alert_bus_o
);
  import lockstep_pkg::*;

  typedef enum logic [2:0] {
    idle,
    read_req,
    read_wait,
    write_req,
    write_wait
  } state_e;

  state_e     state_q, state_d;
  burst_cnt_t cnt_q, cnt_d;
  data_t      sum_q, sum_d;
  logic       alert_q;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    sum_d   = sum_q;
    unique case (state_q)
      idle: begin
        if (core_i.fetch_en) begin
          state_d = read_req;
        end
      end
      read_req: begin
        if (core_i.data_gnt) begin
          state_d = read_wait;
        end
      end
      read_wait: begin
        if (core_i.data_rvalid) begin
          sum_d = sum_q + core_i.data_rdata;
          if (cnt_q == burst_cnt_t'(BURST_LEN - 1)) begin
            state_d = write_req;
          end else begin
            cnt_d   = cnt_q + 1'b1;
            state_d = read_req;
          end
        end
      end
      write_req: begin
        if (core_i.data_gnt) begin
          state_d = write_wait;
        end
      end
      write_wait: begin
        if (core_i.data_rvalid) begin
          // Burst done, start over from the base address
          sum_d   = '0;
          cnt_d   = '0;
          state_d = core_i.fetch_en ? read_req : idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
      cnt_q   <= '0;
      sum_q   <= '0;
      alert_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      sum_q   <= sum_d;
      alert_q <= core_i.data_rvalid & core_i.data_err;
    end
  end

  ////////////////////////////////////////
  // Bus outputs
  ////////////////////////////////////////

  // Held stable from state registers until the grant
  assign core_o.data_req   = (state_q == read_req) || (state_q == write_req);
  assign core_o.data_we    = (state_q == write_req);
  assign core_o.data_addr  = (state_q == write_req) ? WRITE_ADDR
                                                    : BASE_ADDR + (addr_t'(cnt_q) << 2);
  assign core_o.data_wdata = sum_q;

  assign alert_bus_o = alert_q;

endmodule

// ==== lockstep_delay.sv ====
/*
  Shift register delaying a packed vector by Depth cycles, Depth at least 1.
  All stages clear on reset, so the output is zero for Depth cycles after it.
*/
`timescale 1ns/1ps

module lockstep_delay #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Depth-1:0][Width-1:0] stage_q;

  // Stage 0 takes the input, the last stage drives the output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[Depth-1];

endmodule

// ==== lockstep_shadow.sv ====
/*
  Shadow path of the checker. Main core inputs are delayed by LockstepOffset
  cycles and fed to a second acc_core that runs on the late shadow reset.
  Shadow outputs are registered once more to line up with the main delay line.
*/
`timescale 1ns/1ps

module lockstep_shadow #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    shadow_rst_ni,
  input  lockstep_pkg::core_in_t  main_in_i,
  output lockstep_pkg::core_out_t shadow_out_o,
  output logic                    shadow_alert_bus_o
);
  import lockstep_pkg::*;

  core_in_t  shadow_in;
  core_out_t shadow_out_d;

  ////////////////////////////////////////
  // Input delay
  ////////////////////////////////////////

  lockstep_delay #(
    .Width ($bits(core_in_t)),
    .Depth (LockstepOffset)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (main_in_i),
    .q_o    (shadow_in)
  );

  ////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////

  acc_core u_shadow_core (
    .clk_i       (clk_i),
    .rst_ni      (shadow_rst_ni),
    .core_i      (shadow_in),
    .core_o      (shadow_out_d),
    .alert_bus_o (shadow_alert_bus_o)
  );

  // One extra stage, matched by LockstepOffset+1 on the main side
  always_ff @(posedge clk_i) begin
    shadow_out_o <= shadow_out_d;
  end

endmodule

// ==== lockstep_cmp_ctrl.sv ====
/*
  Startup control and output compare. The shadow reset is released exactly
  LockstepOffset edges after rst_ni rises and the compare starts one edge later.
  LockstepOffset must be at least 2.
*/
`timescale 1ns/1ps

module lockstep_cmp_ctrl #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_out_t main_out_dly_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  input  logic                    shadow_alert_bus_i,
  output logic                    shadow_rst_no,
  output logic                    alert_major_internal_o,
  output logic                    alert_major_bus_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  typedef logic [CntW-1:0] startup_cnt_t;

  localparam startup_cnt_t CntMax = startup_cnt_t'(LockstepOffset - 1);

  startup_cnt_t startup_cnt_q;
  logic         shadow_set_q;
  logic         enable_cmp_q;

  ////////////////////////////////////////
  // Startup sequence
  ////////////////////////////////////////

  // Counter saturates, set flop follows one edge after it reaches the top
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      startup_cnt_q <= '0;
      shadow_set_q  <= 1'b0;
      enable_cmp_q  <= 1'b0;
    end else begin
      if (startup_cnt_q != CntMax) begin
        startup_cnt_q <= startup_cnt_q + 1'b1;
      end
      shadow_set_q <= (startup_cnt_q == CntMax);
      enable_cmp_q <= shadow_set_q;
    end
  end

  assign shadow_rst_no = shadow_set_q;

  ////////////////////////////////////////
  // Compare and alerts
  ////////////////////////////////////////

  assign alert_major_internal_o = enable_cmp_q & (main_out_dly_i != shadow_out_i);

  // Already a registered single-cycle pulse from the shadow core
  assign alert_major_bus_o = shadow_alert_bus_i;

endmodule

// ==== core_lockstep.sv ====
/*
  Lockstep checker top level. Takes the main core's inputs and outputs, runs a
  shadow core LockstepOffset cycles behind and compares the outputs.
  LockstepOffset must be at least 2. No back-pressure, values are taken every cycle.
*/
`timescale 1ns/1ps

module core_lockstep #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  main_in_i,
  input  lockstep_pkg::core_out_t main_out_i,
  output logic                    alert_major_internal_o,
  output logic                    alert_major_bus_o
);
  import lockstep_pkg::*;

  // Main outputs wait one extra cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  if (LockstepOffset < 2) begin : gen_offset_check
    $error("LockstepOffset must be at least 2");
  end

  core_out_t main_out_dly;
  core_out_t shadow_out;
  logic      shadow_alert_bus;
  logic      shadow_rst_n;

  lockstep_delay #(
    .Width ($bits(core_out_t)),
    .Depth (OutputsOffset)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (main_out_i),
    .q_o    (main_out_dly)
  );

  lockstep_shadow #(
    .LockstepOffset (LockstepOffset)
  ) u_shadow (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .shadow_rst_ni      (shadow_rst_n),
    .main_in_i          (main_in_i),
    .shadow_out_o       (shadow_out),
    .shadow_alert_bus_o (shadow_alert_bus)
  );

  lockstep_cmp_ctrl #(
    .LockstepOffset (LockstepOffset)
  ) u_cmp_ctrl (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .main_out_dly_i         (main_out_dly),
    .shadow_out_i           (shadow_out),
    .shadow_alert_bus_i     (shadow_alert_bus),
    .shadow_rst_no          (shadow_rst_n),
    .alert_major_internal_o (alert_major_internal_o),
    .alert_major_bus_o      (alert_major_bus_o)
  );

endmodule

// ==== tb_lockstep_sva.sv ====
/*
  Concurrent checks on the checker alerts, bound into core_lockstep.
  Alerts must be quiet in reset and for LockstepOffset+1 cycles after it.
*/
`timescale 1ns/1ps

module tb_lockstep_sva #(
  parameter int unsigned LockstepOffset = 2
) (
  input logic clk_i,
  input logic rst_ni,
  input logic alert_int_i,
  input logic alert_bus_i
);

  int unsigned since_rst_q;

  // Cycles since reset release, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= 0;
    end else if (since_rst_q < 255) begin
      since_rst_q <= since_rst_q + 1;
    end
  end

  assert property (@(posedge clk_i) !rst_ni |-> !alert_int_i && !alert_bus_i)
    else $error("Alert raised while reset is asserted");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (since_rst_q <= LockstepOffset) |-> !alert_int_i && !alert_bus_i)
    else $error("Alert raised during the startup window");

  assert property (@(posedge clk_i) disable iff (!rst_ni) alert_bus_i |=> !alert_bus_i)
    else $error("Bus alert lasted more than one cycle");

endmodule

bind core_lockstep tb_lockstep_sva #(
  .LockstepOffset (LockstepOffset)
) u_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .alert_int_i (alert_major_internal_o),
  .alert_bus_i (alert_major_bus_o)
);

// ==== tb_lockstep.sv ====
/*
  Directed testbench for core_lockstep with LockstepOffset of 2.
  A main acc_core runs against a memory model. Fault hooks change only what
  the DUT sees of the main core. Assertions must be enabled in the simulator.
*/
`timescale 1ns/1ps

module tb_lockstep;
  import lockstep_pkg::*;

  localparam int    Offset   = 2;
  // Request, grant and response take three cycles per access
  localparam int    BurstCyc = 3 * (BURST_LEN + 1);
  // Reset, 8 clean bursts, up to 2 bursts per fault test, then margin
  localparam int    MaxCycles = 8 + 14 * BurstCyc + 50;
  localparam data_t FlipMask  = 32'h0000_0020;
  localparam logic [31:0] Seed = 32'h3a01_1f82;

  logic        clk;
  logic        rst_n;
  core_in_t    main_in, in_flip, dut_in;
  core_out_t   main_out, out_flip, dut_out;
  logic        main_alert_bus, alert_int, alert_bus;
  logic [31:0] rand_state;
  logic        req_seen;
  core_out_t   granted;
  data_t       exp_sum;
  int          read_idx, write_cnt, cyc, err_cnt, check_cnt;
  int          err_req, err_ack, err_cyc, corrupt_req, corrupt_ack;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  assign dut_in  = main_in ^ in_flip;
  assign dut_out = main_out ^ out_flip;

  acc_core u_main_core (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .core_i      (main_in),
    .core_o      (main_out),
    .alert_bus_o (main_alert_bus)
  );

  core_lockstep #(
    .LockstepOffset (Offset)
  ) u_core_lockstep (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .main_in_i              (dut_in),
    .main_out_i             (dut_out),
    .alert_major_internal_o (alert_int),
    .alert_major_bus_o      (alert_bus)
  );

  function automatic logic [31:0] next_rand(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(string name, data_t got, data_t exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %s got %h exp %h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic check_quiet();
    check_eq("alert_major_internal_o", data_t'(alert_int), 32'h0);
    check_eq("alert_major_bus_o", data_t'(alert_bus), 32'h0);
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  // Grant one cycle after a request, respond the cycle after the grant
  initial begin : memory_model
    data_t rdata;
    rand_state = Seed;
    main_in   <= '0;
    in_flip   <= '0;
    req_seen  <= 1'b0;
    granted   <= '0;
    exp_sum   <= '0;
    forever begin
      @(negedge clk);
      main_in.data_gnt    <= 1'b0;
      main_in.data_rvalid <= 1'b0;
      main_in.data_err    <= 1'b0;
      main_in.fetch_en    <= 1'b1;
      in_flip             <= '0;
      if (!rst_n) begin
        req_seen <= 1'b0;
        exp_sum  <= '0;
        read_idx <= 0;
      end else if (main_in.data_gnt) begin
        main_in.data_rvalid <= 1'b1;
        if (granted.data_we) begin
          // Sum of the burst lands right after the read window
          check_eq("data_addr", granted.data_addr, BASE_ADDR + 4 * BURST_LEN);
          check_eq("data_wdata", granted.data_wdata, exp_sum);
          exp_sum   <= '0;
          read_idx  <= 0;
          write_cnt <= write_cnt + 1;
        end else begin
          rdata = next_rand(rand_state);
          rand_state = rdata;
          main_in.data_rdata <= rdata;
          exp_sum  <= exp_sum + rdata;
          read_idx <= read_idx + 1;
          if (err_req != err_ack) begin
            main_in.data_err <= 1'b1;
            err_ack <= err_req;
            err_cyc <= cyc;
          end else if (corrupt_req != corrupt_ack) begin
            in_flip.data_rdata <= 32'h0000_0100;
            corrupt_ack <= corrupt_req;
          end
        end
      end else if (main_out.data_req && req_seen) begin
        main_in.data_gnt <= 1'b1;
        req_seen <= 1'b0;
        granted  <= main_out;
        if (!main_out.data_we) begin
          check_eq("data_addr", main_out.data_addr, BASE_ADDR + addr_t'(4 * read_idx));
        end
      end else if (main_out.data_req) begin
        req_seen <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Alerts stay low until the given number of further writes is seen
  task automatic run_clean(int bursts);
    int target;
    target = write_cnt + bursts;
    while (write_cnt < target) begin
      @(negedge clk);
      check_quiet();
    end
  endtask

  task automatic flip_wdata();
    int t;
    for (int k = 0; k < 6; k++) begin
      @(negedge clk);
      if (k == 0) t = cyc;
      check_eq("alert_major_internal_o", data_t'(alert_int),
               data_t'(cyc == t + Offset + 1));
      check_eq("alert_major_bus_o", data_t'(alert_bus), 32'h0);
      out_flip.data_wdata = (k == 0) ? FlipMask : '0;
    end
  endtask

  task automatic corrupt_rdata();
    int waited;
    @(posedge clk);
    corrupt_req = corrupt_req + 1;
    wait (corrupt_ack == corrupt_req);
    waited = 0;
    while (!alert_int && waited < BurstCyc + Offset + 1) begin
      @(negedge clk);
      waited++;
    end
    assert (alert_int) else begin
      err_cnt++;
      $display("Internal alert did not rise after the corrupted read");
    end
    // Both sums clear once the write is done
    waited = 0;
    while (alert_int && waited < BurstCyc + Offset + 1) begin
      @(negedge clk);
      waited++;
    end
    assert (!alert_int) else begin
      err_cnt++;
      $display("Internal alert did not clear after the burst ended");
    end
  endtask

  task automatic bus_error();
    @(posedge clk);
    err_req = err_req + 1;
    wait (err_ack == err_req);
    for (int k = 1; k <= Offset + 3; k++) begin
      @(negedge clk);
      check_eq("alert_major_bus_o", data_t'(alert_bus), data_t'(cyc == err_cyc + Offset + 1));
      check_eq("main alert_bus_o", data_t'(main_alert_bus), data_t'(cyc == err_cyc + 1));
      check_eq("alert_major_internal_o", data_t'(alert_int), 32'h0);
    end
  endtask

  task automatic reset_mid_run();
    for (int k = 0; k <= Offset + 1; k++) begin
      @(negedge clk);
      out_flip.data_wdata = (k == 0) ? FlipMask : '0;
    end
    check_eq("alert_major_internal_o", data_t'(alert_int), 32'h1);
    rst_n = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_quiet();
    end
    rst_n = 1'b1;
    run_clean(2);
  endtask

  initial begin : stimulus
    out_flip    = '0;
    err_req     = 0;
    corrupt_req = 0;
    apply_reset();
    run_clean(6);
    flip_wdata();
    corrupt_rdata();
    bus_error();
    reset_mid_run();
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cyc >= MaxCycles);
    $display("Timeout: tests did not complete within %0d cycles", MaxCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== tb.f ====
lockstep_pkg.sv
acc_core.sv
lockstep_delay.sv
lockstep_shadow.sv
lockstep_cmp_ctrl.sv
core_lockstep.sv
tb_lockstep_sva.sv
tb_lockstep.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the lockstep testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_lockstep -f tb.f -o sim_lockstep
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_lockstep 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
